//--- common/rv_pkg.sv
`default_nettype none

package rv_pkg;

  // machine word and register file geometry
  localparam int xlen_c = 32;
  localparam int nregs_c = 32;

  typedef logic [xlen_c-1:0] word_t;
  typedef logic [$clog2(nregs_c)-1:0] reg_idx_t;

  // first fetch address after reset
  localparam word_t reset_pc_c = 32'h0000_0000;

  // base opcodes handled by this core, everything else decodes as illegal
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_system = 7'b1110011
  } opcode_e;

  // encoded as {funct7[5], funct3} so that R-type maps straight across
  typedef enum logic [3:0] {
    alu_add  = 4'b0000,
    alu_sll  = 4'b0001,
    alu_slt  = 4'b0010,
    alu_sltu = 4'b0011,
    alu_xor  = 4'b0100,
    alu_srl  = 4'b0101,
    alu_or   = 4'b0110,
    alu_and  = 4'b0111,
    alu_sub  = 4'b1000,
    alu_sra  = 4'b1101
  } alu_op_e;

  // same values as the branch funct3 field
  typedef enum logic [2:0] {
    cond_eq  = 3'b000,
    cond_ne  = 3'b001,
    cond_lt  = 3'b100,
    cond_ge  = 3'b101,
    cond_ltu = 3'b110,
    cond_geu = 3'b111
  } branch_cond_e;

  // write-back source
  typedef enum logic [1:0] {
    wb_alu      = 2'b00,
    wb_pc_plus4 = 2'b01,
    wb_load     = 2'b10,
    wb_none     = 2'b11
  } wb_sel_e;

  typedef struct packed {
    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    word_t        imm;
    alu_op_e      alu_op;
    logic         use_pc_a;
    logic         use_imm_b;
    logic         branch;
    branch_cond_e cond;
    logic         jal;
    logic         jalr;
    logic         mem_read;
    logic         mem_write;
    wb_sel_e      wb_sel;
    logic         halt;
    logic         illegal;
  } decoded_t;

  // wishbone classic, master to slave
  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    word_t      adr;
    word_t      dat;
    logic [3:0] sel;
  } wb_req_t;

  // wishbone classic, slave to master
  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

endpackage

`default_nettype wire

//--- logic/insn_decoder.sv
`default_nettype none

module insn_decoder (
  input  rv_pkg::word_t    i_insn,
  output rv_pkg::decoded_t o_dec
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;

  assign opcode = opcode_e'(i_insn[6:0]);
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];

  // sign-extended immediates, one per format
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  always_comb begin
    o_dec = '0;
    o_dec.rs1 = i_insn[19:15];
    o_dec.rs2 = i_insn[24:20];
    o_dec.rd = i_insn[11:7];
    o_dec.imm = imm_i;
    o_dec.alu_op = alu_add;
    o_dec.cond = branch_cond_e'(funct3);
    o_dec.wb_sel = wb_none;
    case (opcode)
      opc_lui: begin
        // x0 + imm
        o_dec.rs1 = '0;
        o_dec.imm = imm_u;
        o_dec.use_imm_b = 1'b1;
        o_dec.wb_sel = wb_alu;
      end
      opc_auipc: begin
        o_dec.imm = imm_u;
        o_dec.use_pc_a = 1'b1;
        o_dec.use_imm_b = 1'b1;
        o_dec.wb_sel = wb_alu;
      end
      opc_op_imm: begin
        o_dec.use_imm_b = 1'b1;
        o_dec.wb_sel = wb_alu;
        case (funct3)
          3'b001: begin
            if (funct7 == 7'b0000000) begin
              o_dec.alu_op = alu_sll;
            end else begin
              o_dec.illegal = 1'b1;
            end
          end
          3'b101: begin
            if (funct7 == 7'b0000000) begin
              o_dec.alu_op = alu_srl;
            end else if (funct7 == 7'b0100000) begin
              o_dec.alu_op = alu_sra;
            end else begin
              o_dec.illegal = 1'b1;
            end
          end
          // imm[30] is data here, not a sub/sra select
          default: o_dec.alu_op = alu_op_e'({1'b0, funct3});
        endcase
      end
      opc_op: begin
        o_dec.wb_sel = wb_alu;
        if (funct7 == 7'b0000000) begin
          o_dec.alu_op = alu_op_e'({1'b0, funct3});
        end else if (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)) begin
          o_dec.alu_op = alu_op_e'({1'b1, funct3});
        end else begin
          // includes the whole M extension (funct7 = 1)
          o_dec.illegal = 1'b1;
        end
      end
      opc_branch: begin
        o_dec.imm = imm_b;
        o_dec.branch = 1'b1;
        o_dec.illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      opc_jal: begin
        o_dec.imm = imm_j;
        o_dec.jal = 1'b1;
        o_dec.wb_sel = wb_pc_plus4;
      end
      opc_jalr: begin
        o_dec.use_imm_b = 1'b1;
        o_dec.jalr = 1'b1;
        o_dec.wb_sel = wb_pc_plus4;
        o_dec.illegal = (funct3 != 3'b000);
      end
      opc_load: begin
        o_dec.use_imm_b = 1'b1;
        o_dec.mem_read = 1'b1;
        o_dec.wb_sel = wb_load;
        // word access only
        o_dec.illegal = (funct3 != 3'b010);
      end
      opc_store: begin
        o_dec.imm = imm_s;
        o_dec.use_imm_b = 1'b1;
        o_dec.mem_write = 1'b1;
        o_dec.illegal = (funct3 != 3'b010);
      end
      opc_system: begin
        // only ecall, every other field zero
        o_dec.halt = (i_insn[31:7] == 25'd0);
        o_dec.illegal = (i_insn[31:7] != 25'd0);
      end
      default: o_dec.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/alu.sv
`default_nettype none

module alu (
  input  rv_pkg::alu_op_e      i_op,
  input  rv_pkg::word_t        i_a,
  input  rv_pkg::word_t        i_b,
  input  rv_pkg::branch_cond_e i_cond,
  output rv_pkg::word_t        o_result,
  output logic                 o_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = i_b[4:0];

  // shared by slt/sltu and the branch compare
  assign lt_s = $signed(i_a) < $signed(i_b);
  assign lt_u = i_a < i_b;
  assign eq = (i_a == i_b);

  always_comb begin
    case (i_op)
      alu_add: o_result = i_a + i_b;
      alu_sub: o_result = i_a - i_b;
      alu_sll: o_result = i_a << shamt;
      alu_slt: o_result = word_t'(lt_s);
      alu_sltu: o_result = word_t'(lt_u);
      alu_xor: o_result = i_a ^ i_b;
      alu_srl: o_result = i_a >> shamt;
      alu_sra: o_result = $unsigned($signed(i_a) >>> shamt);
      alu_or: o_result = i_a | i_b;
      alu_and: o_result = i_a & i_b;
      default: o_result = '0;
    endcase
  end

  // branch outcome, independent of i_op
  always_comb begin
    case (i_cond)
      cond_eq: o_taken = eq;
      cond_ne: o_taken = !eq;
      cond_lt: o_taken = lt_s;
      cond_ge: o_taken = !lt_s;
      cond_ltu: o_taken = lt_u;
      cond_geu: o_taken = !lt_u;
      default: o_taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t i_rs1,
  input  rv_pkg::reg_idx_t i_rs2,
  output rv_pkg::word_t    o_rs1_data,
  output rv_pkg::word_t    o_rs2_data,
  input  logic             i_we,
  input  rv_pkg::reg_idx_t i_rd,
  input  rv_pkg::word_t    i_rd_data
);
  import rv_pkg::*;

  word_t regs [nregs_c];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < nregs_c; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && (i_rd != '0)) begin
      regs[i_rd] <= i_rd_data;
    end
  end

  // combinational read
  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  // x0 must read zero on both ports, whatever was written to it
  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    ((i_rs1 == '0) -> (o_rs1_data == '0)) && ((i_rs2 == '0) -> (o_rs2_data == '0)));

endmodule

`default_nettype wire

//--- core/core_control.sv
`default_nettype none

module core_control (
  input  logic                 clk,
  input  logic                 rst,
  output rv_pkg::word_t        o_insn,
  input  rv_pkg::decoded_t     i_dec,
  input  rv_pkg::word_t        i_rs1_data,
  input  rv_pkg::word_t        i_rs2_data,
  output rv_pkg::alu_op_e      o_alu_op,
  output rv_pkg::word_t        o_alu_a,
  output rv_pkg::word_t        o_alu_b,
  output rv_pkg::branch_cond_e o_cond,
  input  rv_pkg::word_t        i_alu_result,
  input  logic                 i_taken,
  output logic                 o_rf_we,
  output rv_pkg::reg_idx_t     o_rf_rd,
  output rv_pkg::word_t        o_rf_data,
  output rv_pkg::wb_req_t      o_ibus,
  input  rv_pkg::wb_rsp_t      i_ibus,
  output rv_pkg::wb_req_t      o_dbus,
  input  rv_pkg::wb_rsp_t      i_dbus,
  output logic                 o_halt,
  output logic                 o_illegal
);
  import rv_pkg::*;

  typedef enum logic [1:0] {
    st_fetch,
    st_execute,
    st_memory,
    st_halted
  } state_e;

  state_e state_q;
  word_t  pc_q;
  word_t  insn_q;
  logic   ibus_cyc_q;
  logic   dbus_cyc_q;
  logic   dbus_we_q;
  word_t  dbus_adr_q;
  word_t  dbus_dat_q;
  logic   illegal_q;
  word_t  pc_plus4;
  word_t  pc_target;
  word_t  pc_next;
  logic   is_mem;
  logic   misaligned;
  logic   stop;
  logic   ibus_done;
  logic   dbus_done;

  assign ibus_done = ibus_cyc_q && i_ibus.ack;
  assign dbus_done = dbus_cyc_q && i_dbus.ack;

  // operand select for the ALU and the branch compare
  assign o_insn = insn_q;
  assign o_alu_op = i_dec.alu_op;
  assign o_cond = i_dec.cond;
  assign o_alu_a = i_dec.use_pc_a ? pc_q : i_rs1_data;
  assign o_alu_b = i_dec.use_imm_b ? i_dec.imm : i_rs2_data;

  assign pc_plus4 = pc_q + 32'd4;
  assign pc_target = pc_q + i_dec.imm;
  assign is_mem = i_dec.mem_read || i_dec.mem_write;
  assign misaligned = is_mem && (i_alu_result[1:0] != 2'b00);
  assign stop = i_dec.halt || i_dec.illegal || misaligned;

  always_comb begin
    pc_next = pc_plus4;
    if (i_dec.jalr) begin
      pc_next = {i_alu_result[xlen_c-1:1], 1'b0};
    end else if (i_dec.jal || (i_dec.branch && i_taken)) begin
      pc_next = pc_target;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_fetch;
      pc_q <= reset_pc_c;
      ibus_cyc_q <= 1'b0;
      dbus_cyc_q <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      case (state_q)
        st_fetch: begin
          // request raised one cycle after reset and held until ack
          ibus_cyc_q <= !ibus_done;
          if (ibus_done) begin
            state_q <= st_execute;
          end
        end
        st_execute: begin
          if (stop) begin
            state_q <= st_halted;
            illegal_q <= i_dec.illegal || misaligned;
          end else if (is_mem) begin
            dbus_cyc_q <= 1'b1;
            state_q <= st_memory;
          end else begin
            pc_q <= pc_next;
            ibus_cyc_q <= 1'b1;
            state_q <= st_fetch;
          end
        end
        st_memory: begin
          if (dbus_done) begin
            dbus_cyc_q <= 1'b0;
            pc_q <= pc_plus4;
            ibus_cyc_q <= 1'b1;
            state_q <= st_fetch;
          end
        end
        default: begin
          // halted until reset
          state_q <= st_halted;
        end
      endcase
    end
  end

  // instruction and data request payload
  always_ff @(posedge clk) begin
    if (rst) begin
      insn_q <= '0;
    end else if (ibus_done) begin
      insn_q <= i_ibus.dat;
    end
    if (state_q == st_execute) begin
      dbus_adr_q <= i_alu_result;
      dbus_dat_q <= i_rs2_data;
      dbus_we_q <= i_dec.mem_write;
    end
  end

  always_comb begin
    o_rf_we = 1'b0;
    if (state_q == st_execute) begin
      o_rf_we = !stop && (i_dec.wb_sel inside {wb_alu, wb_pc_plus4});
    end else if (state_q == st_memory) begin
      o_rf_we = dbus_done && (i_dec.wb_sel == wb_load);
    end
  end

  assign o_rf_rd = i_dec.rd;

  always_comb begin
    case (i_dec.wb_sel)
      wb_alu: o_rf_data = i_alu_result;
      wb_pc_plus4: o_rf_data = pc_plus4;
      wb_load: o_rf_data = i_dbus.dat;
      default: o_rf_data = '0;
    endcase
  end

  always_comb begin
    o_ibus = '0;
    o_ibus.cyc = ibus_cyc_q;
    o_ibus.stb = ibus_cyc_q;
    o_ibus.adr = pc_q;
    o_ibus.sel = 4'hf;
    o_dbus.cyc = dbus_cyc_q;
    o_dbus.stb = dbus_cyc_q;
    o_dbus.we = dbus_we_q;
    o_dbus.adr = dbus_adr_q;
    o_dbus.dat = dbus_dat_q;
    o_dbus.sel = 4'hf;
  end

  assign o_halt = (state_q == st_halted);
  assign o_illegal = illegal_q;

  // address held across wait states on both masters
  a_ibus_adr_stable: assert property (@(posedge clk) disable iff (rst)
    (o_ibus.stb && !i_ibus.ack) |=> $stable(o_ibus.adr));
  a_dbus_adr_stable: assert property (@(posedge clk) disable iff (rst)
    (o_dbus.stb && !i_dbus.ack) |=> $stable(o_dbus.adr));

  a_dbus_aligned: assert property (@(posedge clk) disable iff (rst)
    o_dbus.stb |-> (o_dbus.adr[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- core/rv_core.sv
`default_nettype none

module rv_core (
  input  logic            clk,
  input  logic            rst,
  output rv_pkg::wb_req_t o_ibus,
  input  rv_pkg::wb_rsp_t i_ibus,
  output rv_pkg::wb_req_t o_dbus,
  input  rv_pkg::wb_rsp_t i_dbus,
  output logic            o_halt,
  output logic            o_illegal
);
  import rv_pkg::*;

  word_t        insn;
  decoded_t     dec;
  word_t        rs1_data;
  word_t        rs2_data;
  alu_op_e      alu_op;
  word_t        alu_a;
  word_t        alu_b;
  branch_cond_e cond;
  word_t        alu_result;
  logic         taken;
  logic         rf_we;
  reg_idx_t     rf_rd;
  word_t        rf_data;

  core_control i_core_control (
    .clk          (clk),
    .rst          (rst),
    .o_insn       (insn),
    .i_dec        (dec),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .o_alu_op     (alu_op),
    .o_alu_a      (alu_a),
    .o_alu_b      (alu_b),
    .o_cond       (cond),
    .i_alu_result (alu_result),
    .i_taken      (taken),
    .o_rf_we      (rf_we),
    .o_rf_rd      (rf_rd),
    .o_rf_data    (rf_data),
    .o_ibus       (o_ibus),
    .i_ibus       (i_ibus),
    .o_dbus       (o_dbus),
    .i_dbus       (i_dbus),
    .o_halt       (o_halt),
    .o_illegal    (o_illegal)
  );

  insn_decoder i_insn_decoder (
    .i_insn (insn),
    .o_dec  (dec)
  );

  alu i_alu (
    .i_op     (alu_op),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .i_cond   (cond),
    .o_result (alu_result),
    .o_taken  (taken)
  );

  // read indices come straight from the decoded instruction
  reg_file i_reg_file (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (dec.rs1),
    .i_rs2      (dec.rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (rf_we),
    .i_rd       (rf_rd),
    .i_rd_data  (rf_data)
  );

endmodule

`default_nettype wire

//--- testbench/tb_mem.sv
`default_nettype none

module tb_mem (
  input  logic            clk,
  input  logic            i_rst,
  input  rv_pkg::wb_req_t i_req,
  output rv_pkg::wb_rsp_t o_rsp
);
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int depth_c = 256;
  localparam int log_depth_c = 128;

  word_t      mem [depth_c];
  word_t      log_adr [log_depth_c];
  word_t      log_dat [log_depth_c];
  int         log_cnt = 0;
  int         starts = 0;
  integer     seed;
  int         wait_cnt;
  logic       pending;
  logic       cyc_q = 1'b0;
  logic [7:0] idx;

  task automatic clear_mem();
    for (int i = 0; i < depth_c; i++) begin
      mem[i] = '0;
    end
    log_cnt = 0;
    starts = 0;
  endtask

  task automatic write_word(input int index, input word_t value);
    mem[index] = value;
  endtask

  // complete the current transfer, stores go to the log
  task automatic respond();
    idx = i_req.adr[9:2];
    o_rsp.ack = 1'b1;
    if (i_req.we) begin
      mem[idx] = i_req.dat;
      if (log_cnt < log_depth_c) begin
        log_adr[log_cnt] = i_req.adr;
        log_dat[log_cnt] = i_req.dat;
      end
      log_cnt++;
      o_rsp.dat = '0;
    end else begin
      o_rsp.dat = mem[idx];
    end
  endtask

  // count new bus cycles, sampled before the master updates
  always @(posedge clk) begin
    if (i_req.cyc && !cyc_q) begin
      starts++;
    end
    cyc_q = i_req.cyc;
  end

  // ack driven on the falling edge, 0 to 3 wait states per transfer
  initial begin
    seed = 46445;
    o_rsp = '0;
    wait_cnt = 0;
    pending = 1'b0;
    forever begin
      @(negedge clk);
      if (i_rst) begin
        o_rsp = '0;
        pending = 1'b0;
      end else if (o_rsp.ack) begin
        // transfer finished on the last rising edge
        o_rsp = '0;
      end else if (i_req.cyc && i_req.stb) begin
        if (!pending) begin
          pending = 1'b1;
          wait_cnt = {$random(seed)} % 4;
        end
        if (wait_cnt == 0) begin
          respond();
          pending = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int halt_timeout_c = 5000;
  localparam int settle_cycles_c = 8;
  localparam word_t out_base_c = 32'h100;
  localparam word_t wrong_adr_c = 32'h3f0;
  localparam word_t skip_marker_c = 32'h0bd;
  localparam word_t good_marker_c = 32'h2c5;

  logic    clk;
  logic    rst;
  logic    rst_q = 1'b0;
  wb_req_t ibus_req;
  wb_rsp_t ibus_rsp;
  wb_req_t dbus_req;
  wb_rsp_t dbus_rsp;
  logic    halt;
  logic    illegal;

  int     errors;
  int     timeouts;
  integer seed;
  word_t  prog [$];
  word_t  exp_adr [$];
  word_t  exp_dat [$];
  word_t  out_adr;

  rv_core i_rv_core (
    .clk       (clk),
    .rst       (rst),
    .o_ibus    (ibus_req),
    .i_ibus    (ibus_rsp),
    .o_dbus    (dbus_req),
    .i_dbus    (dbus_rsp),
    .o_halt    (halt),
    .o_illegal (illegal)
  );

  tb_mem i_imem (
    .clk   (clk),
    .i_rst (rst),
    .i_req (ibus_req),
    .o_rsp (ibus_rsp)
  );

  tb_mem i_dmem (
    .clk   (clk),
    .i_rst (rst),
    .i_req (dbus_req),
    .o_rsp (dbus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  always @(posedge clk) begin
    rst_q <= rst;
  end

  task automatic report_error(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  // quiet outputs from the second reset cycle to the first cycle after it
  a_reset_quiet: assert property (@(posedge clk) rst_q |->
      (!ibus_req.cyc && !ibus_req.stb && !dbus_req.cyc && !dbus_req.stb && !halt && !illegal))
    else report_error("bus or status output active around reset");
  a_first_fetch: assert property (@(posedge clk) (rst_q && !rst) |=>
      (ibus_req.cyc && ibus_req.stb && !ibus_req.we && ibus_req.adr == reset_pc_c))
    else report_error("first fetch missing or not at the reset address");
  a_stb_cyc: assert property (@(posedge clk) disable iff (rst)
      (!ibus_req.stb || ibus_req.cyc) && (!dbus_req.stb || dbus_req.cyc))
    else report_error("stb high without cyc");
  a_ibus_hold: assert property (@(posedge clk) disable iff (rst)
      (ibus_req.stb && !ibus_rsp.ack) |=> (ibus_req.stb && $stable(ibus_req.adr)))
    else report_error("ibus request changed before ack");
  a_dbus_hold: assert property (@(posedge clk) disable iff (rst)
      (dbus_req.stb && !dbus_rsp.ack) |=>
      (dbus_req.stb && $stable(dbus_req.adr) && $stable(dbus_req.we) && $stable(dbus_req.dat)))
    else report_error("dbus request changed before ack");
  a_ibus_release: assert property (@(posedge clk) disable iff (rst)
      (ibus_req.stb && ibus_rsp.ack) |=> !ibus_req.stb)
    else report_error("ibus stb not dropped after ack");
  a_dbus_release: assert property (@(posedge clk) disable iff (rst)
      (dbus_req.stb && dbus_rsp.ack) |=> !dbus_req.stb)
    else report_error("dbus stb not dropped after ack");
  a_ibus_read_only: assert property (@(posedge clk) disable iff (rst)
      ibus_req.stb |-> !ibus_req.we)
    else report_error("write on the instruction bus");
  a_store_sel: assert property (@(posedge clk) disable iff (rst)
      (dbus_req.stb && dbus_req.we) |-> (dbus_req.sel == 4'hf))
    else report_error("store without all byte selects");
  a_halted_idle: assert property (@(posedge clk) disable iff (rst)
      halt |-> (!ibus_req.cyc && !dbus_req.cyc))
    else report_error("bus cycle while halted");
  a_illegal_halts: assert property (@(posedge clk) disable iff (rst)
      illegal |-> halt)
    else report_error("illegal flag without halt");

  // instruction formats, field order as in the RV32I spec
  function automatic word_t rtype(input logic [6:0] f7, input logic [2:0] f3,
                                  input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic word_t itype(input int imm, input logic [2:0] f3, input int rd,
                                  input int rs1, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  // always a word store
  function automatic word_t stype(input int imm, input int rs2, input int rs1);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic word_t btype(input int imm, input logic [2:0] f3,
                                  input int rs1, input int rs2);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic word_t utype(input word_t value, input int rd, input logic [6:0] opc);
    return {value[31:12], rd[4:0], opc};
  endfunction

  function automatic word_t jtype(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic word_t next_pc();
    return word_t'(prog.size() * 4);
  endfunction

  task automatic emit(input word_t insn);
    prog.push_back(insn);
  endtask

  task automatic start_program();
    prog.delete();
    exp_adr.delete();
    exp_dat.delete();
    out_adr = out_base_c;
  endtask

  // lui and addi pair, upper part rounded for the signed low half
  task automatic load_const(input int rd, input word_t value);
    word_t upper;
    upper = value + 32'h800;
    emit(utype(upper, rd, 7'b0110111));
    emit(itype(value, 3'b000, rd, rd, 7'b0010011));
  endtask

  task automatic store_check(input int rs, input word_t value);
    emit(stype(out_adr, rs, 0));
    exp_adr.push_back(out_adr);
    exp_dat.push_back(value);
    out_adr += 4;
  endtask

  task automatic alu_rr(input logic [6:0] f7, input logic [2:0] f3, input word_t value);
    emit(rtype(f7, f3, 3, 1, 2));
    store_check(3, value);
  endtask

  task automatic alu_ri(input logic [2:0] f3, input int imm, input word_t value);
    emit(itype(imm, f3, 3, 1, 7'b0010011));
    store_check(3, value);
  endtask

  task automatic ecall();
    emit(itype(0, 3'b000, 0, 0, 7'b1110011));
  endtask

  task automatic build_alu_program();
    word_t      a;
    word_t      b;
    word_t      imm;
    word_t      pc;
    logic [4:0] sh;
    a = 32'h9abc_def1;
    b = 32'h1234_5685;
    imm = 32'hffff_fffb;
    sh = b[4:0];
    load_const(1, a);
    load_const(2, b);
    alu_rr(7'h00, 3'b000, a + b);
    alu_rr(7'h20, 3'b000, a - b);
    alu_rr(7'h00, 3'b001, a << sh);
    alu_rr(7'h00, 3'b010, word_t'($signed(a) < $signed(b)));
    alu_rr(7'h00, 3'b011, word_t'(a < b));
    alu_rr(7'h00, 3'b100, a ^ b);
    alu_rr(7'h00, 3'b101, a >> sh);
    alu_rr(7'h20, 3'b101, word_t'($signed(a) >>> sh));
    alu_rr(7'h00, 3'b110, a | b);
    alu_rr(7'h00, 3'b111, a & b);
    alu_ri(3'b000, -5, a + imm);
    alu_ri(3'b010, -5, word_t'($signed(a) < $signed(imm)));
    alu_ri(3'b011, -5, word_t'(a < imm));
    alu_ri(3'b100, -5, a ^ imm);
    alu_ri(3'b110, -5, a | imm);
    alu_ri(3'b111, -5, a & imm);
    alu_ri(3'b001, 7, a << 7);
    alu_ri(3'b101, 7, a >> 7);
    alu_ri(3'b101, 32'h407, word_t'($signed(a) >>> 7));
    emit(utype(32'habcd_e000, 3, 7'b0110111));
    store_check(3, 32'habcd_e000);
    pc = next_pc();
    emit(utype(32'h0001_2000, 3, 7'b0010111));
    store_check(3, pc + 32'h0001_2000);
    // write to x0 must be dropped
    emit(itype(55, 3'b000, 0, 0, 7'b0010011));
    store_check(0, '0);
    ecall();
  endtask

  // slot store after the branch runs only when the branch falls through
  task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2,
                             input word_t a, input word_t b);
    emit(btype(8, f3, rs1, rs2));
    emit(stype(out_adr, 30, 0));
    if (!branch_taken(f3, a, b)) begin
      exp_adr.push_back(out_adr);
      exp_dat.push_back(skip_marker_c);
    end
    out_adr += 4;
    store_check(29, good_marker_c);
  endtask

  task automatic build_branch_program();
    word_t pc;
    emit(itype(5, 3'b000, 1, 0, 7'b0010011));
    emit(itype(-3, 3'b000, 2, 0, 7'b0010011));
    emit(itype(5, 3'b000, 3, 0, 7'b0010011));
    emit(itype(good_marker_c, 3'b000, 29, 0, 7'b0010011));
    emit(itype(skip_marker_c, 3'b000, 30, 0, 7'b0010011));
    branch_case(3'b000, 1, 3, 32'd5, 32'd5);
    branch_case(3'b000, 1, 2, 32'd5, -32'sd3);
    branch_case(3'b001, 1, 2, 32'd5, -32'sd3);
    branch_case(3'b001, 1, 3, 32'd5, 32'd5);
    branch_case(3'b100, 2, 1, -32'sd3, 32'd5);
    branch_case(3'b100, 1, 2, 32'd5, -32'sd3);
    branch_case(3'b101, 1, 2, 32'd5, -32'sd3);
    branch_case(3'b101, 2, 1, -32'sd3, 32'd5);
    branch_case(3'b110, 1, 2, 32'd5, -32'sd3);
    branch_case(3'b110, 2, 1, -32'sd3, 32'd5);
    branch_case(3'b111, 2, 1, -32'sd3, 32'd5);
    branch_case(3'b111, 1, 2, 32'd5, -32'sd3);
    // jal over two wrong-path stores
    pc = next_pc();
    emit(jtype(12, 5));
    emit(stype(wrong_adr_c, 30, 0));
    emit(stype(wrong_adr_c, 30, 0));
    store_check(5, pc + 4);
    // jalr target has bit 0 set, which must be cleared
    pc = next_pc();
    emit(itype(pc + 17, 3'b000, 6, 0, 7'b0010011));
    emit(itype(0, 3'b000, 7, 6, 7'b1100111));
    emit(stype(wrong_adr_c, 30, 0));
    emit(stype(wrong_adr_c, 30, 0));
    store_check(7, pc + 8);
    ecall();
  endtask

  task automatic build_memory_program();
    word_t value;
    word_t adr;
    emit(itype(32'h280, 3'b000, 4, 0, 7'b0010011));
    for (int k = 0; k < 6; k++) begin
      value = $random(seed);
      adr = 32'h280 + 4 * k;
      load_const(1, value);
      emit(stype(adr, 1, 0));
      exp_adr.push_back(adr);
      exp_dat.push_back(value);
      emit(itype(4 * k, 3'b010, 2, 4, 7'b0000011));
      store_check(2, value);
    end
    ecall();
  endtask

  task automatic build_mul_program();
    emit(itype(3, 3'b000, 1, 0, 7'b0010011));
    emit(itype(7, 3'b000, 2, 0, 7'b0010011));
    emit(rtype(7'h01, 3'b000, 3, 1, 2));
    emit(stype(out_adr, 3, 0));
    ecall();
  endtask

  task automatic build_misaligned_program();
    emit(itype(32'h102, 3'b000, 1, 0, 7'b0010011));
    emit(itype(0, 3'b010, 3, 1, 7'b0000011));
    emit(stype(out_adr, 3, 0));
    ecall();
  endtask

  task automatic check_stores(input string name);
    assert (i_dmem.log_cnt == exp_adr.size())
      else report_error($sformatf("%s: %0d stores seen, %0d expected", name,
                                  i_dmem.log_cnt, exp_adr.size()));
    for (int k = 0; k < exp_adr.size() && k < i_dmem.log_cnt; k++) begin
      assert (i_dmem.log_adr[k] == exp_adr[k] && i_dmem.log_dat[k] == exp_dat[k])
        else report_error($sformatf("%s: store %0d is %h <- %h, expected %h <- %h", name, k,
                                    i_dmem.log_adr[k], i_dmem.log_dat[k], exp_adr[k],
                                    exp_dat[k]));
    end
  endtask

  task automatic run_program(input logic expect_illegal, input string name);
    int cycles;
    int ibus_starts;
    int dbus_starts;
    @(negedge clk);
    rst = 1'b1;
    i_imem.clear_mem();
    i_dmem.clear_mem();
    foreach (prog[k]) begin
      i_imem.write_word(k, prog[k]);
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    cycles = 0;
    while (!halt && cycles < halt_timeout_c) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt) begin
      timeouts++;
      $display("timeout: the %s program did not halt within %0d cycles", name,
               halt_timeout_c);
    end
    // nothing may start once halted
    ibus_starts = i_imem.starts;
    dbus_starts = i_dmem.starts;
    repeat (settle_cycles_c) @(negedge clk);
    assert (i_imem.starts == ibus_starts && i_dmem.starts == dbus_starts)
      else report_error($sformatf("%s: bus cycle started after halt", name));
    assert (illegal == expect_illegal)
      else report_error($sformatf("%s: illegal flag is %b", name, illegal));
    if (expect_illegal) begin
      assert (dbus_starts == 0)
        else report_error($sformatf("%s: %0d data bus cycles", name, dbus_starts));
    end
    check_stores(name);
  endtask

  initial begin
    rst = 1'b1;
    errors = 0;
    timeouts = 0;
    seed = 46445;
    out_adr = out_base_c;
    start_program();
    build_alu_program();
    run_program(1'b0, "alu");
    start_program();
    build_branch_program();
    run_program(1'b0, "branch");
    start_program();
    build_memory_program();
    run_program(1'b0, "memory");
    start_program();
    build_mul_program();
    run_program(1'b1, "mul");
    start_program();
    build_misaligned_program();
    run_program(1'b1, "misaligned");
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
common/rv_pkg.sv
logic/insn_decoder.sv
logic/alu.sv
logic/reg_file.sv
core/core_control.sv
core/rv_core.sv
testbench/tb_mem.sv
testbench/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - target: rtl
    files:
      - common/rv_pkg.sv
      - logic/insn_decoder.sv
      - logic/alu.sv
      - logic/reg_file.sv
      - core/core_control.sv
      - core/rv_core.sv
  - target: test
    files:
      - testbench/tb_mem.sv
      - testbench/tb_rv_core.sv
